/* decode_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module decode_unit (
    input  logic            clk,
    input  logic            reset_i,
    input  rv_pkg::if_id_t  if_i,
    input  rv_pkg::mem_wb_t wb_i,
    output rv_pkg::id_ex_t  id_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] rf [32];
    logic [31:0]     instr;
    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;
    logic [4:0]      rs1_idx;
    logic [4:0]      rs2_idx;
    logic            wr_en;
    logic [XLEN-1:0] rs1_val;
    logic [XLEN-1:0] rs2_val;

    assign instr  = if_i.instr;
    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    // x0 is never written
    assign wr_en = wb_i.valid && wb_i.wb_en && (wb_i.rd != 5'd0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wr_en) begin
            rf[wb_i.rd] <= wb_i.wdata;
        end
    end

    // same-cycle writeback is passed straight through
    always_comb begin
        rs1_val = (rs1_idx == 5'd0) ? '0 : rf[rs1_idx];
        rs2_val = (rs2_idx == 5'd0) ? '0 : rf[rs2_idx];
        if (wr_en && (wb_i.rd == rs1_idx)) begin
            rs1_val = wb_i.wdata;
        end
        if (wr_en && (wb_i.rd == rs2_idx)) begin
            rs2_val = wb_i.wdata;
        end
    end

    always_comb begin
        id_o       = '0;
        id_o.pc    = if_i.pc;
        id_o.instr = instr;
        id_o.rd    = instr[11:7];
        rs1_idx    = instr[19:15];
        rs2_idx    = instr[24:20];
        case (opcode)
            OP_IMM: begin
                id_o.imm     = {{20{instr[31]}}, instr[31:20]};
                id_o.use_imm = 1'b1;
                id_o.wb_en   = 1'b1;
                id_o.valid   = if_i.valid;
                rs2_idx      = 5'd0;
                case (funct3)
                    3'b000:  id_o.alu_op = ALU_ADD;
                    3'b111:  id_o.alu_op = ALU_AND;
                    3'b110:  id_o.alu_op = ALU_OR;
                    3'b100:  id_o.alu_op = ALU_XOR;
                    3'b010:  id_o.alu_op = ALU_SLT;
                    default: id_o.valid  = 1'b0;
                endcase
            end
            OP_REG: begin
                id_o.wb_en = 1'b1;
                id_o.valid = if_i.valid && (funct7 == 7'b0000000);
                case (funct3)
                    3'b000: begin
                        id_o.alu_op = (funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
                        id_o.valid  = if_i.valid &&
                                      ((funct7 == 7'b0000000) || (funct7 == 7'b0100000));
                    end
                    3'b111:  id_o.alu_op = ALU_AND;
                    3'b110:  id_o.alu_op = ALU_OR;
                    3'b100:  id_o.alu_op = ALU_XOR;
                    3'b010:  id_o.alu_op = ALU_SLT;
                    default: id_o.valid  = 1'b0;
                endcase
            end
            OP_LUI: begin
                id_o.imm     = {instr[31:12], 12'b0};
                id_o.alu_op  = ALU_PASS_B;
                id_o.use_imm = 1'b1;
                id_o.wb_en   = 1'b1;
                id_o.valid   = if_i.valid;
                rs1_idx      = 5'd0;
                rs2_idx      = 5'd0;
            end
            OP_LOAD: begin
                id_o.imm     = {{20{instr[31]}}, instr[31:20]};
                id_o.use_imm = 1'b1;
                id_o.is_load = 1'b1;
                id_o.wb_en   = 1'b1;
                id_o.valid   = if_i.valid && (funct3 == 3'b010);
                rs2_idx      = 5'd0;
            end
            OP_STORE: begin
                id_o.imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                id_o.use_imm  = 1'b1;
                id_o.is_store = 1'b1;
                id_o.valid    = if_i.valid && (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                id_o.imm = {{19{instr[31]}}, instr[31], instr[7],
                            instr[30:25], instr[11:8], 1'b0};
                id_o.is_branch = 1'b1;
                id_o.branch_ne = funct3[0];
                id_o.valid     = if_i.valid && (funct3[2:1] == 2'b00);
            end
            OP_JAL: begin
                id_o.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
                id_o.is_jal = 1'b1;
                id_o.wb_en  = 1'b1;
                id_o.valid  = if_i.valid;
                rs1_idx     = 5'd0;
                rs2_idx     = 5'd0;
            end
            default: id_o.valid = 1'b0;
        endcase
        id_o.rs1     = rs1_idx;
        id_o.rs2     = rs2_idx;
        id_o.rs1_val = rs1_val;
        id_o.rs2_val = rs2_val;
    end

endmodule

`default_nettype wire

/* execute_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  rv_pkg::id_ex_t          ex_i,
    input  rv_pkg::ex_mem_t         ex_mem_fwd_i,
    input  rv_pkg::mem_wb_t         mem_wb_fwd_i,
    input  rv_pkg::fwd_sel_e        fwd_a_i,
    input  rv_pkg::fwd_sel_e        fwd_b_i,
    output rv_pkg::ex_mem_t         ex_o,
    output logic                    redirect_o,
    output logic [rv_pkg::XLEN-1:0] redirect_pc_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] rs2_fwd;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic            taken;

    // operand sources picked by pipeline_ctrl
    always_comb begin
        case (fwd_a_i)
            FWD_EX_MEM: op_a = ex_mem_fwd_i.alu_res;
            FWD_MEM_WB: op_a = mem_wb_fwd_i.wdata;
            default:    op_a = ex_i.rs1_val;
        endcase
        case (fwd_b_i)
            FWD_EX_MEM: rs2_fwd = ex_mem_fwd_i.alu_res;
            FWD_MEM_WB: rs2_fwd = mem_wb_fwd_i.wdata;
            default:    rs2_fwd = ex_i.rs2_val;
        endcase
    end

    assign op_b = ex_i.use_imm ? ex_i.imm : rs2_fwd;

    always_comb begin
        case (ex_i.alu_op)
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_OR:     alu_out = op_a | op_b;
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SLT:    alu_out = XLEN'($signed(op_a) < $signed(op_b));
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = op_a + op_b;
        endcase
    end

    // beq and bne differ only in the sense of the compare
    assign taken         = ex_i.is_branch && ((op_a == rs2_fwd) != ex_i.branch_ne);
    assign redirect_o    = ex_i.valid && (taken || ex_i.is_jal);
    assign redirect_pc_o = ex_i.pc + ex_i.imm;

    always_comb begin
        ex_o.valid      = ex_i.valid;
        ex_o.pc         = ex_i.pc;
        ex_o.instr      = ex_i.instr;
        ex_o.rd         = ex_i.rd;
        ex_o.wb_en      = ex_i.wb_en;
        ex_o.is_load    = ex_i.is_load;
        ex_o.is_store   = ex_i.is_store;
        ex_o.alu_res    = ex_i.is_jal ? (ex_i.pc + XLEN'(4)) : alu_out;
        ex_o.store_data = rs2_fwd;
    end

endmodule

`default_nettype wire

/* fetch_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     stall_i,
    input  logic                     redirect_i,
    input  logic [rv_pkg::XLEN-1:0]  redirect_pc_i,
    input  logic [31:0]              imem_data_i,
    output logic [rv_pkg::XLEN-1:0]  imem_addr_o,
    output rv_pkg::if_id_t           if_o
);

    import rv_pkg::*;

    logic [XLEN-1:0] pc_q;

    // redirect from execute beats a load-use hold
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= '0;
        end else if (redirect_i) begin
            pc_q <= redirect_pc_i;
        end else if (!stall_i) begin
            pc_q <= pc_q + XLEN'(4);
        end
    end

    assign imem_addr_o = pc_q;

    assign if_o.valid = !reset_i;
    assign if_o.pc    = pc_q;
    assign if_o.instr = imem_data_i;

endmodule

`default_nettype wire

/* filelist.f */
rv_pkg.sv
stage_reg.sv
fetch_unit.sv
decode_unit.sv
execute_unit.sv
pipeline_ctrl.sv
mem_unit.sv
rv_core_top.sv
rv_checker.sv
tb_rv_core.sv

/* mem_unit.sv */
`timescale 1ns/100ps
`default_nettype none

module mem_unit (
    input  logic            clk,
    input  rv_pkg::ex_mem_t mem_i,
    output rv_pkg::mem_wb_t wb_o
);

    import rv_pkg::*;

    logic [XLEN-1:0]    dmem [DMEM_WORDS];
    logic [DMEM_AW-1:0] word_addr;
    logic [XLEN-1:0]    load_data;

    // power-up contents are zero
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
    end

    // word index, upper address bits ignored
    assign word_addr = mem_i.alu_res[DMEM_AW+1:2];
    assign load_data = dmem[word_addr];

    always_ff @(posedge clk) begin
        if (mem_i.valid && mem_i.is_store) begin
            dmem[word_addr] <= mem_i.store_data;
        end
    end

    assign wb_o.valid = mem_i.valid;
    assign wb_o.pc    = mem_i.pc;
    assign wb_o.instr = mem_i.instr;
    assign wb_o.rd    = mem_i.rd;
    assign wb_o.wb_en = mem_i.wb_en;
    assign wb_o.wdata = mem_i.is_load ? load_data : mem_i.alu_res;

endmodule

`default_nettype wire

/* pipeline_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

module pipeline_ctrl (
    input  rv_pkg::id_ex_t   id_i,
    input  rv_pkg::id_ex_t   ex_i,
    input  rv_pkg::ex_mem_t  ex_mem_i,
    input  rv_pkg::mem_wb_t  mem_wb_i,
    input  logic             redirect_i,
    output logic             pc_stall_o,
    output logic             if_id_stall_o,
    output logic             if_id_flush_o,
    output logic             id_ex_flush_o,
    output rv_pkg::fwd_sel_e fwd_a_o,
    output rv_pkg::fwd_sel_e fwd_b_o
);

    import rv_pkg::*;

    logic load_use;
    logic ex_mem_wr;
    logic mem_wb_wr;

    // decode sources are zero when unused, so x0 never matches
    assign load_use = ex_i.valid && ex_i.is_load && (ex_i.rd != 5'd0) && id_i.valid &&
                      ((id_i.rs1 == ex_i.rd) || (id_i.rs2 == ex_i.rd));

    assign pc_stall_o    = load_use && !redirect_i;
    assign if_id_stall_o = load_use && !redirect_i;
    assign if_id_flush_o = redirect_i;
    assign id_ex_flush_o = redirect_i || load_use;

    assign ex_mem_wr = ex_mem_i.valid && ex_mem_i.wb_en && (ex_mem_i.rd != 5'd0);
    assign mem_wb_wr = mem_wb_i.valid && mem_wb_i.wb_en && (mem_wb_i.rd != 5'd0);

    // younger result wins
    always_comb begin
        fwd_a_o = FWD_RF;
        fwd_b_o = FWD_RF;
        if (ex_mem_wr && (ex_mem_i.rd == ex_i.rs1)) begin
            fwd_a_o = FWD_EX_MEM;
        end else if (mem_wb_wr && (mem_wb_i.rd == ex_i.rs1)) begin
            fwd_a_o = FWD_MEM_WB;
        end
        if (ex_mem_wr && (ex_mem_i.rd == ex_i.rs2)) begin
            fwd_b_o = FWD_EX_MEM;
        end else if (mem_wb_wr && (mem_wb_i.rd == ex_i.rs2)) begin
            fwd_b_o = FWD_MEM_WB;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build and run the rv_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module tb_rv_core -f filelist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_rv_core)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "TEST PASS"; then
    exit 0
fi
exit 1

/* rv_checker.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_checker #(
    parameter int WORDS = 64
) (
    input  logic            clk,
    input  logic            reset_i,
    input  logic [31:0]     prog_i [WORDS],
    input  rv_pkg::retire_t retire_i,
    output logic            end_seen_o,
    output int              err_cnt_o,
    output int              ret_cnt_o
);

    import rv_pkg::*;

    // program size is a power of two
    localparam int          IDX_W  = $clog2(WORDS);
    localparam logic [31:0] END_PC = 32'((WORDS - 1) * 4);

    logic [31:0] regs [32];
    logic [31:0] dmem [DMEM_WORDS];
    logic [31:0] pc;
    logic        in_reset;
    logic        first_seen;
    int          since_reset;
    int          errs;
    int          rets;
    retire_t     exp;

    // model data memory starts out zero like the RAM
    initial begin
        for (int i = 0; i < DMEM_WORDS; i++) begin
            dmem[i] = '0;
        end
        in_reset    = 1'b0;
        first_seen  = 1'b0;
        since_reset = 0;
        errs        = 0;
        rets        = 0;
        end_seen_o  = 1'b0;
        err_cnt_o   = 0;
        ret_cnt_o   = 0;
    end

    task automatic report_error(input string msg);
        $display("ERROR %0t ns: %s", $time, msg);
        errs = errs + 1;
    endtask

    // executes one instruction on the model and returns what should retire
    function automatic retire_t ref_step();
        retire_t     r;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] addr;
        logic [31:0] res;
        logic [31:0] next_pc;
        logic [2:0]  f3;
        ins     = prog_i[pc[IDX_W+1:2]];
        f3      = ins[14:12];
        a       = regs[ins[19:15]];
        b       = regs[ins[24:20]];
        imm_i   = {{20{ins[31]}}, ins[31:20]};
        res     = '0;
        next_pc = pc + 32'd4;
        r       = '0;
        r.valid = 1'b1;
        r.pc    = pc;
        r.instr = ins;
        r.rd    = ins[11:7];
        case (ins[6:0])
            OP_IMM: begin
                r.wb_en = 1'b1;
                case (f3)
                    3'b000:  res = a + imm_i;
                    3'b111:  res = a & imm_i;
                    3'b110:  res = a | imm_i;
                    3'b100:  res = a ^ imm_i;
                    default: res = {31'd0, $signed(a) < $signed(imm_i)};
                endcase
            end
            OP_REG: begin
                r.wb_en = 1'b1;
                case (f3)
                    3'b000:  res = ins[30] ? a - b : a + b;
                    3'b111:  res = a & b;
                    3'b110:  res = a | b;
                    3'b100:  res = a ^ b;
                    default: res = {31'd0, $signed(a) < $signed(b)};
                endcase
            end
            OP_LUI: begin
                r.wb_en = 1'b1;
                res     = {ins[31:12], 12'd0};
            end
            OP_LOAD: begin
                r.wb_en = 1'b1;
                addr    = a + imm_i;
                res     = dmem[addr[DMEM_AW+1:2]];
            end
            OP_STORE: begin
                addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                dmem[addr[DMEM_AW+1:2]] = b;
            end
            OP_BRANCH: begin
                if ((a == b) != f3[0]) begin
                    next_pc = pc + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                    ins[11:8], 1'b0};
                end
            end
            OP_JAL: begin
                r.wb_en = 1'b1;
                res     = pc + 32'd4;
                next_pc = pc + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                ins[30:21], 1'b0};
            end
            default: r.valid = 1'b0;
        endcase
        if (r.wb_en && (r.rd != 5'd0)) begin
            regs[r.rd] = res;
        end
        r.wdata = res;
        pc      = next_pc;
        return r;
    endfunction

    always @(posedge clk) begin
        if (reset_i) begin
            if (in_reset && retire_i.valid) begin
                report_error("retire valid while reset is held");
            end
            for (int i = 0; i < 32; i++) begin
                regs[i] = '0;
            end
            pc          = '0;
            in_reset    = 1'b1;
            first_seen  = 1'b0;
            since_reset = 0;
            end_seen_o <= 1'b0;
        end else begin
            in_reset = 1'b0;
            if (retire_i.valid) begin
                exp  = ref_step();
                rets = rets + 1;
                // first instruction after reset is never stalled or flushed
                if (!first_seen && (since_reset != 4)) begin
                    report_error($sformatf("first retirement %0d cycles after reset, expected 4",
                                           since_reset));
                end
                first_seen = 1'b1;
                if ((retire_i.pc != exp.pc) || (retire_i.instr != exp.instr)) begin
                    report_error($sformatf("retired pc %h instr %h, expected pc %h instr %h",
                                           retire_i.pc, retire_i.instr, exp.pc, exp.instr));
                end else if ((retire_i.rd != exp.rd) || (retire_i.wb_en != exp.wb_en)) begin
                    report_error($sformatf("pc %h rd %0d wb_en %b, expected rd %0d wb_en %b",
                                           exp.pc, retire_i.rd, retire_i.wb_en,
                                           exp.rd, exp.wb_en));
                end else if (exp.wb_en && (retire_i.wdata != exp.wdata)) begin
                    report_error($sformatf("pc %h wdata %h, expected %h",
                                           exp.pc, retire_i.wdata, exp.wdata));
                end
                if (retire_i.pc == END_PC) begin
                    end_seen_o <= 1'b1;
                end
            end
            since_reset = since_reset + 1;
        end
        err_cnt_o <= errs;
        ret_cnt_o <= rets;
    end

endmodule

`default_nettype wire

/* rv_core_top.sv */
`timescale 1ns/100ps
`default_nettype none

module rv_core_top (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic [31:0]             imem_data_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    output rv_pkg::retire_t         retire_o
);

    import rv_pkg::*;

    if_id_t          if_d;
    if_id_t          if_q;
    id_ex_t          id_d;
    id_ex_t          id_q;
    ex_mem_t         ex_d;
    ex_mem_t         ex_q;
    mem_wb_t         mem_d;
    mem_wb_t         mem_q;

    logic            redirect;
    logic [XLEN-1:0] redirect_pc;
    logic            pc_stall;
    logic            if_id_stall;
    logic            if_id_flush;
    logic            id_ex_flush;
    fwd_sel_e        fwd_a;
    fwd_sel_e        fwd_b;

    fetch_unit fetch_u (
        .clk           (clk),
        .reset_i       (reset_i),
        .stall_i       (pc_stall),
        .redirect_i    (redirect),
        .redirect_pc_i (redirect_pc),
        .imem_data_i   (imem_data_i),
        .imem_addr_o   (imem_addr_o),
        .if_o          (if_d)
    );

    stage_reg #(.payload_t(if_id_t)) if_id_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (if_id_stall),
        .flush_i (if_id_flush),
        .d_i     (if_d),
        .q_o     (if_q)
    );

    decode_unit decode_u (
        .clk     (clk),
        .reset_i (reset_i),
        .if_i    (if_q),
        .wb_i    (mem_q),
        .id_o    (id_d)
    );

    stage_reg #(.payload_t(id_ex_t)) id_ex_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (1'b0),
        .flush_i (id_ex_flush),
        .d_i     (id_d),
        .q_o     (id_q)
    );

    execute_unit execute_u (
        .ex_i          (id_q),
        .ex_mem_fwd_i  (ex_q),
        .mem_wb_fwd_i  (mem_q),
        .fwd_a_i       (fwd_a),
        .fwd_b_i       (fwd_b),
        .ex_o          (ex_d),
        .redirect_o    (redirect),
        .redirect_pc_o (redirect_pc)
    );

    stage_reg #(.payload_t(ex_mem_t)) ex_mem_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (ex_d),
        .q_o     (ex_q)
    );

    mem_unit mem_u (
        .clk  (clk),
        .mem_i(ex_q),
        .wb_o (mem_d)
    );

    stage_reg #(.payload_t(mem_wb_t)) mem_wb_reg (
        .clk     (clk),
        .reset_i (reset_i),
        .stall_i (1'b0),
        .flush_i (1'b0),
        .d_i     (mem_d),
        .q_o     (mem_q)
    );

    pipeline_ctrl ctrl_u (
        .id_i          (id_d),
        .ex_i          (id_q),
        .ex_mem_i      (ex_q),
        .mem_wb_i      (mem_q),
        .redirect_i    (redirect),
        .pc_stall_o    (pc_stall),
        .if_id_stall_o (if_id_stall),
        .if_id_flush_o (if_id_flush),
        .id_ex_flush_o (id_ex_flush),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b)
    );

    // writeback stage doubles as the retire report
    assign retire_o.valid = mem_q.valid;
    assign retire_o.pc    = mem_q.pc;
    assign retire_o.instr = mem_q.instr;
    assign retire_o.rd    = mem_q.rd;
    assign retire_o.wb_en = mem_q.wb_en;
    assign retire_o.wdata = mem_q.wdata;

endmodule

`default_nettype wire

/* rv_pkg.sv */
`default_nettype none

package rv_pkg;

    localparam int XLEN       = 32;
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_AW    = $clog2(DMEM_WORDS);

    // base opcodes of the supported subset
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_REG    = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_JAL    = 7'b1101111;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {
        FWD_RF,
        FWD_EX_MEM,
        FWD_MEM_WB
    } fwd_sel_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
    } if_id_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [XLEN-1:0] rs1_val;
        logic [XLEN-1:0] rs2_val;
        logic [XLEN-1:0] imm;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [4:0]      rd;
        alu_op_e         alu_op;
        logic            use_imm;
        logic            is_branch;
        logic            branch_ne;
        logic            is_jal;
        logic            is_load;
        logic            is_store;
        logic            wb_en;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic            wb_en;
        logic            is_load;
        logic            is_store;
        logic [XLEN-1:0] alu_res;
        logic [XLEN-1:0] store_data;
    } ex_mem_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic            wb_en;
        logic [XLEN-1:0] wdata;
    } mem_wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [31:0]     instr;
        logic [4:0]      rd;
        logic            wb_en;
        logic [XLEN-1:0] wdata;
    } retire_t;

endpackage

`default_nettype wire

/* stage_reg.sv */
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = rv_pkg::if_id_t
) (
    input  logic     clk,
    input  logic     reset_i,
    input  logic     stall_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    // only valid is cleared, the rest of a bubble is don't care
    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            q_o.valid <= 1'b0;
        end else if (!stall_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_rv_core;

    import rv_pkg::*;

    localparam int          PROG_WORDS   = 64;
    localparam int          IDX_W        = $clog2(PROG_WORDS);
    localparam int          CLK_PERIOD   = 100;
    localparam int          RESET_CYCLES = 5;
    localparam int          PASSES       = 3;
    // straight-line alu block, no store can be in flight when reset lands here
    localparam int          MID_LO       = 30;
    localparam int          MID_HI       = 35;
    localparam logic [31:0] MID_PC       = 32'(MID_LO * 4);

    logic            clk;
    logic            reset;
    logic [31:0]     imem_data;
    logic [XLEN-1:0] imem_addr;
    retire_t         retire;
    logic [31:0]     prog [PROG_WORDS];
    logic [31:0]     lfsr_q;
    logic            end_seen;
    int              err_cnt;
    int              ret_cnt;
    int              ret_base;
    int              err_base;
    int              bad_tests;

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    assign imem_data = prog[imem_addr[IDX_W+1:2]];

    rv_core_top UUT (
        .clk         (clk),
        .reset_i     (reset),
        .imem_data_i (imem_data),
        .imem_addr_o (imem_addr),
        .retire_o    (retire)
    );

    rv_checker #(.WORDS(PROG_WORDS)) checker_u (
        .clk        (clk),
        .reset_i    (reset),
        .prog_i     (prog),
        .retire_i   (retire),
        .end_seen_o (end_seen),
        .err_cnt_o  (err_cnt),
        .ret_cnt_o  (ret_cnt)
    );

    // galois lfsr, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int k = 0; k < n; k++) begin
            val    = {val[30:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h80200003) : (lfsr_q >> 1);
        end
        return val;
    endfunction

    task automatic build_program();
        logic [3:0]  kind;
        logic [2:0]  op;
        logic [2:0]  f3;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [11:0] imm;
        logic [11:0] addr;
        logic [12:0] boff;
        logic [20:0] joff;
        logic [3:0]  prev_kind;
        logic [4:0]  prev_rd;
        logic [11:0] prev_addr;
        int          tgt;
        prev_kind = 4'd0;
        prev_rd   = 5'd0;
        prev_addr = 12'd0;
        for (int i = 0; i < PROG_WORDS - 1; i++) begin
            kind = 4'(rand_bits(4));
            op   = 3'(rand_bits(3));
            rd   = 5'(rand_bits(3));
            rs1  = 5'(rand_bits(3));
            rs2  = 5'(rand_bits(3));
            imm  = 12'(rand_bits(12));
            addr = {2'b00, 8'(rand_bits(8)), 2'b00};
            tgt  = i + 1 + int'(rand_bits(2));
            if (rand_bits(1) == 32'd1) begin
                rs1 = prev_rd;
            end
            if ((i >= MID_LO) && (i <= MID_HI)) begin
                kind = {1'b0, kind[2:0]};
            end else if ((prev_kind == 4'd11) || (prev_kind == 4'd12)) begin
                // load back what was just stored
                kind = 4'd9;
                addr = prev_addr;
            end else if ((prev_kind == 4'd9) || (prev_kind == 4'd10)) begin
                kind = 4'd4;
                rs1  = prev_rd;
                rs2  = prev_rd;
            end
            // nothing jumps over the alu block
            if ((i < MID_LO) && (tgt > MID_LO)) begin
                tgt = MID_LO;
            end else if (tgt > PROG_WORDS - 1) begin
                tgt = PROG_WORDS - 1;
            end
            boff = 13'((tgt - i) * 4);
            joff = 21'((tgt - i) * 4);
            case (op)
                3'd0, 3'd5: f3 = 3'b000;
                3'd1, 3'd6: f3 = 3'b111;
                3'd2, 3'd7: f3 = 3'b110;
                3'd3:       f3 = 3'b100;
                default:    f3 = 3'b010;
            endcase
            case (kind)
                4'd0, 4'd1, 4'd2, 4'd3: prog[i] = {imm, rs1, f3, rd, OP_IMM};
                4'd4, 4'd5, 4'd6, 4'd7: begin
                    prog[i] = {(op == 3'd5) ? 7'b0100000 : 7'b0000000,
                               rs2, rs1, f3, rd, OP_REG};
                end
                4'd8:         prog[i] = {20'(rand_bits(20)), rd, OP_LUI};
                4'd9, 4'd10:  prog[i] = {addr, 5'd0, 3'b010, rd, OP_LOAD};
                4'd11, 4'd12: prog[i] = {addr[11:5], rs2, 5'd0, 3'b010, addr[4:0], OP_STORE};
                4'd13, 4'd14: begin
                    prog[i] = {boff[12], boff[10:5], rs2, rs1, 2'b00, ~kind[0],
                               boff[4:1], boff[11], OP_BRANCH};
                end
                default: prog[i] = {joff[20], joff[10:1], joff[11], joff[19:12], rd, OP_JAL};
            endcase
            prev_kind = kind;
            prev_rd   = rd;
            prev_addr = addr;
        end
        // jal x0 to itself
        prog[PROG_WORDS-1] = {20'd0, 5'd0, OP_JAL};
    endtask

    task automatic hold_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
    endtask

    task automatic wait_for_end();
        while (!end_seen) begin
            @(posedge clk);
        end
    endtask

    task automatic report_test(input int num, input string name);
        int rets;
        int errs;
        rets     = ret_cnt - ret_base;
        errs     = err_cnt - err_base;
        ret_base = ret_cnt;
        err_base = err_cnt;
        if ((errs != 0) || (rets == 0)) begin
            bad_tests = bad_tests + 1;
        end
        $display("test %0d, %s: %0d retired, %0d errors, %s", num, name, rets, errs,
                 ((errs == 0) && (rets > 0)) ? "ok" : "failed");
    endtask

    initial begin
        reset <= 1'b1;
        lfsr_q    = 32'hb44ac0c9;
        ret_base  = 0;
        err_base  = 0;
        bad_tests = 0;
        build_program();
        hold_reset();
        wait_for_end();
        report_test(1, "full program after power-up reset");
        reset <= 1'b1;
        hold_reset();
        do begin
            @(posedge clk);
        end while (!(retire.valid && (retire.pc == MID_PC)));
        reset <= 1'b1;
        hold_reset();
        report_test(2, "program cut short by reset in the alu block");
        wait_for_end();
        report_test(3, "full program after mid-run reset");
        $display("summary: 3 tests, %0d retirements, %0d errors", ret_cnt, err_cnt);
        if ((err_cnt == 0) && (bad_tests == 0)) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(CLK_PERIOD * (4 * PROG_WORDS * PASSES + PASSES * RESET_CYCLES + 20));
        $display("watchdog expired: the program did not reach its end");
        $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire
